//--- fifo_demo_pkg.sv
// FIFO demo shared definitions

package fifo_demo_pkg;

  // ------------------------------
  // word and pattern widths
  // ------------------------------

  // one FIFO word, also one pattern value
  localparam int unsigned data_width = 4;

  typedef logic [data_width - 1:0] data_t;

  // the table covers every 4-bit value once
  localparam int unsigned pattern_len = 2 ** data_width;

  // index into the pattern table, wraps by itself at 16
  typedef logic [3:0] pattern_idx_t;

  // fixed permutation pushed in order, entry i goes with push i mod 16
  localparam data_t pattern_table [pattern_len] = '{
    4'h2, 4'h6, 4'hd, 4'hb, 4'h7, 4'he, 4'hc, 4'h4,
    4'h1, 4'h0, 4'h9, 4'ha, 4'hf, 4'h5, 4'h8, 4'h3
  };

  // ------------------------------
  // lane numbering and credits
  // ------------------------------

  // upper bound on n_lanes, sets the lane number width
  localparam int unsigned max_lanes = 8;

  // lane number
  typedef logic [2:0] lane_idx_t;

  // credit count or lane occupancy, good for depth up to 15
  typedef logic [3:0] credit_t;

endpackage

//--- lane_if.sv
// FIFO lane interface

`timescale 1ns/1ns

interface lane_if;

  import fifo_demo_pkg::*;

  // write side, from the pattern source
  logic  push;
  data_t push_data;

  // read side, from the drain
  logic  pop;

  // head word, valid while nonempty is high
  data_t pop_data;
  logic  nonempty;

  // one-cycle pulse the cycle after each pop
  logic  credit_return;

  modport src (
    output push, push_data,
    input  credit_return
  );

  modport lane (
    input  push, push_data, pop,
    output pop_data, nonempty, credit_return
  );

  modport drn (
    output pop,
    input  pop_data, nonempty
  );

endinterface

//--- pattern_source.sv
// FIFO demo pattern source

`timescale 1ns/1ns

module pattern_source #(
  parameter int unsigned n_lanes = 4,
  parameter int unsigned depth   = 4
) (
  input  logic clk,
  input  logic arst_n,
  input  logic push_en,
  output logic push_ready,
  lane_if.src  lanes [n_lanes]
);

  import fifo_demo_pkg::*;

  // ------------------------------
  // index and write lane
  // ------------------------------

  pattern_idx_t idx;
  lane_idx_t    wr_lane;
  data_t        cur_data;

  // one bit per possible lane, set while that lane has credit
  logic [max_lanes - 1:0] has_credit;

  logic push_fire;

  // the table lookup runs off the index counter
  assign cur_data = pattern_table[idx];

  // a push goes through only when the current lane has credit
  assign push_ready = has_credit[wr_lane];
  assign push_fire  = push_en && push_ready;

  // index and lane pointer move together on every accepted push
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      idx     <= '0;
      wr_lane <= '0;
    end else if (push_fire) begin
      // index is 4 bits wide, so it wraps after entry 15
      idx <= idx + 1'b1;
      if (wr_lane == lane_idx_t'(n_lanes - 1)) begin
        wr_lane <= '0;
      end else begin
        wr_lane <= wr_lane + 1'b1;
      end
    end
  end

  // ------------------------------
  // per-lane credit counters
  // ------------------------------

  for (genvar g = 0; g < max_lanes; g++) begin : g_credit
    if (g < n_lanes) begin : g_live
      credit_t credit;
      logic    push_sel;

      assign push_sel = push_fire && (wr_lane == lane_idx_t'(g));

      // only the addressed lane sees push and data
      assign lanes[g].push      = push_sel;
      assign lanes[g].push_data = push_sel ? cur_data : '0;

      assign has_credit[g] = (credit != '0);

      // push spends one, return gives one back, both at once cancel
      always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
          credit <= credit_t'(depth);
        end else if (push_sel && !lanes[g].credit_return) begin
          credit <= credit - 1'b1;
        end else if (lanes[g].credit_return && !push_sel) begin
          credit <= credit + 1'b1;
        end
      end

      // returns never outnumber pushes, so the count stays within depth
      a_credit_bound: assert property (
        @(posedge clk) disable iff (!arst_n)
        credit <= credit_t'(depth)
      );
    end else begin : g_unused
      // lanes beyond n_lanes never have credit
      assign has_credit[g] = 1'b0;
    end
  end

endmodule

//--- flip_flop_fifo_with_counter.sv
// FIFO lane with occupancy counter

`timescale 1ns/1ns

module flip_flop_fifo_with_counter #(
  parameter int unsigned depth = 4
) (
  input  logic  clk,
  input  logic  arst_n,
  lane_if.lane  port
);

  import fifo_demo_pkg::*;

  // pointer width, at least one bit even for a single entry
  localparam int unsigned ptr_w = (depth > 1) ? $clog2(depth) : 1;

  typedef logic [ptr_w - 1:0] ptr_t;

  // ------------------------------
  // storage and pointers
  // ------------------------------

  data_t   mem [depth];
  ptr_t    wr_ptr;
  ptr_t    rd_ptr;
  credit_t count;

  // write into the array, no reset on the payload
  always_ff @(posedge clk) begin
    if (port.push) begin
      mem[wr_ptr] <= port.push_data;
    end
  end

  // pointers wrap at depth, which need not be a power of two
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (port.push) begin
        wr_ptr <= (wr_ptr == ptr_t'(depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (port.pop) begin
        rd_ptr <= (rd_ptr == ptr_t'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
    end
  end

  // ------------------------------
  // occupancy and credit return
  // ------------------------------

  // push and pop together leave the count alone
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      count <= '0;
    end else if (port.push && !port.pop) begin
      count <= count + 1'b1;
    end else if (port.pop && !port.push) begin
      count <= count - 1'b1;
    end
  end

  // each pop hands one credit back a cycle later
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      port.credit_return <= 1'b0;
    end else begin
      port.credit_return <= port.pop;
    end
  end

  // head word is valid whenever the lane holds something
  assign port.nonempty = (count != '0);
  assign port.pop_data = mem[rd_ptr];

  // the source credit scheme must keep a full lane from seeing a push
  a_no_push_full: assert property (
    @(posedge clk) disable iff (!arst_n)
    port.push |-> count != credit_t'(depth)
  );

  // the drain only pops a lane that reports nonempty
  a_no_pop_empty: assert property (
    @(posedge clk) disable iff (!arst_n)
    port.pop |-> count != '0
  );

endmodule

//--- lane_drain.sv
// FIFO demo lane drain

`timescale 1ns/1ns

module lane_drain #(
  parameter int unsigned n_lanes = 4
) (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 pop_en,
  lane_if.drn                  lanes [n_lanes],
  output logic                 out_valid,
  output fifo_demo_pkg::data_t out_data
);

  import fifo_demo_pkg::*;

  // ------------------------------
  // head gather
  // ------------------------------

  // padded to max_lanes so the lane number indexes them directly
  logic  [max_lanes - 1:0] head_valid;
  data_t [max_lanes - 1:0] head_data;

  lane_idx_t rd_lane;
  logic      pop_fire;

  // pop only when asked and the lane in turn has a word
  assign pop_fire = pop_en && head_valid[rd_lane];

  for (genvar g = 0; g < max_lanes; g++) begin : g_tap
    if (g < n_lanes) begin : g_live
      assign head_valid[g] = lanes[g].nonempty;
      assign head_data[g]  = lanes[g].pop_data;
      assign lanes[g].pop  = pop_fire && (rd_lane == lane_idx_t'(g));
    end else begin : g_unused
      assign head_valid[g] = 1'b0;
      assign head_data[g]  = '0;
    end
  end

  // ------------------------------
  // rotation and output stage
  // ------------------------------

  // read pointer holds while the current lane is empty
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_lane   <= '0;
      out_valid <= 1'b0;
    end else begin
      out_valid <= pop_fire;
      if (pop_fire) begin
        if (rd_lane == lane_idx_t'(n_lanes - 1)) begin
          rd_lane <= '0;
        end else begin
          rd_lane <= rd_lane + 1'b1;
        end
      end
    end
  end

  // popped word, only loaded on a pop
  always_ff @(posedge clk) begin
    if (pop_fire) begin
      out_data <= head_data[rd_lane];
    end
  end

  // a popped head word was written by the lane before, so it is never unknown
  a_out_known: assert property (
    @(posedge clk) disable iff (!arst_n)
    out_valid |-> !$isunknown(out_data)
  );

endmodule

//--- fifo_demo_top.sv
// FIFO demo top level

`timescale 1ns/1ns

module fifo_demo_top #(
  parameter int unsigned n_lanes = 4,
  parameter int unsigned depth   = 4
) (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 push_en,
  input  logic                 pop_en,
  output logic                 push_ready,
  output logic                 out_valid,
  output fifo_demo_pkg::data_t out_data
);

  // ------------------------------
  // lane bundles
  // ------------------------------

  // one interface per lane, shared by source, lane and drain
  lane_if lanes [n_lanes] ();

  // pattern writer with credit pacing
  pattern_source #(
    .n_lanes (n_lanes),
    .depth   (depth)
  ) u_source (
    .clk        (clk),
    .arst_n     (arst_n),
    .push_en    (push_en),
    .push_ready (push_ready),
    .lanes      (lanes)
  );

  // identical lanes, written and read in strict rotation
  for (genvar g = 0; g < n_lanes; g++) begin : g_lane
    flip_flop_fifo_with_counter #(
      .depth (depth)
    ) u_lane (
      .clk    (clk),
      .arst_n (arst_n),
      .port   (lanes[g])
    );
  end

  // round-robin reader, restores table order
  lane_drain #(
    .n_lanes (n_lanes)
  ) u_drain (
    .clk       (clk),
    .arst_n    (arst_n),
    .pop_en    (pop_en),
    .lanes     (lanes),
    .out_valid (out_valid),
    .out_data  (out_data)
  );

endmodule

//--- tb_fifo_demo.sv
// FIFO demo testbench

`timescale 1ns/1ns

module tb_fifo_demo;

  localparam int n_lanes = 4;
  localparam int depth   = 4;
  localparam int n_rows  = 9;

  // input modes in the stimulus table
  localparam int mode_low  = 0;
  localparam int mode_high = 1;
  localparam int mode_rand = 2;

  // expected push order, one full pass of the permutation
  localparam logic [3:0] ref_pattern [16] = '{
    4'h2, 4'h6, 4'hd, 4'hb, 4'h7, 4'he, 4'hc, 4'h4,
    4'h1, 4'h0, 4'h9, 4'ha, 4'hf, 4'h5, 4'h8, 4'h3
  };

  logic       clk     = 1'b0;
  logic       arst_n  = 1'b0;
  logic       push_en = 1'b0;
  logic       pop_en  = 1'b0;
  logic       push_ready;
  logic       out_valid;
  logic [3:0] out_data;

  // ------------------------------
  // stimulus table
  // ------------------------------

  string row_name [n_rows];
  int    row_push [n_rows];
  int    row_pop [n_rows];
  int    row_cycles [n_rows];
  // -1 means the count is not fixed
  int    row_exp_push [n_rows];
  int    row_exp_out [n_rows];

  // ------------------------------
  // reference model
  // ------------------------------

  int         m_credit [n_lanes];
  int         m_occ [n_lanes];
  int         m_ret [n_lanes];
  int         m_wr;
  int         m_rd;
  int         m_push_cnt;
  logic       m_valid;
  logic [3:0] m_queue [$];

  int errors;
  int checks;
  int row_push_cnt;
  int row_out_cnt;
  int cycle_cnt;
  int cycle_limit;

  fifo_demo_top #(
    .n_lanes (n_lanes),
    .depth   (depth)
  ) u_dut (
    .clk        (clk),
    .arst_n     (arst_n),
    .push_en    (push_en),
    .pop_en     (pop_en),
    .push_ready (push_ready),
    .out_valid  (out_valid),
    .out_data   (out_data)
  );

  // 100 ns period
  always #50 clk = ~clk;

  // run limit guard
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt > cycle_limit) begin
      $display("timeout: run went past %0d cycles", cycle_limit);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  task automatic set_row(input int r, input string name, input int push_mode,
                         input int pop_mode, input int cycles, input int exp_push,
                         input int exp_out);
    row_name[r]     = name;
    row_push[r]     = push_mode;
    row_pop[r]      = pop_mode;
    row_cycles[r]   = cycles;
    row_exp_push[r] = exp_push;
    row_exp_out[r]  = exp_out;
  endtask

  function automatic logic pick(input int mode);
    int unsigned r;
    r = $urandom;
    if (mode == mode_rand) begin
      return r[0];
    end
    return (mode == mode_high);
  endfunction

  // check outputs against the model, then advance it by one clock edge
  task automatic step_model();
    logic       exp_ready;
    logic       push_fire;
    logic       pop_fire;
    logic [3:0] exp_word;
    exp_ready = (m_credit[m_wr] != 0);
    checks += 2;
    if (push_ready !== exp_ready) begin
      errors++;
      $display("CHECK FAILED t=%0t push_ready expected %0b got %0b", $time, exp_ready,
               push_ready);
    end
    if (out_valid !== m_valid) begin
      errors++;
      $display("CHECK FAILED t=%0t out_valid expected %0b got %0b", $time, m_valid,
               out_valid);
    end
    if (out_valid === 1'b1) begin
      row_out_cnt++;
      if (m_queue.size() == 0) begin
        errors++;
        $display("output word at t=%0t with no word left in the model", $time);
      end else begin
        exp_word = m_queue.pop_front();
        checks++;
        if (out_data !== exp_word) begin
          errors++;
          $display("CHECK FAILED t=%0t out_data expected %h got %h", $time, exp_word,
                   out_data);
        end
      end
    end
    push_fire = push_en && exp_ready;
    pop_fire  = pop_en && (m_occ[m_rd] != 0);
    // credits see last cycle's return, occupancy sees this edge
    for (int l = 0; l < n_lanes; l++) begin
      m_credit[l] = m_credit[l] + m_ret[l] - int'(push_fire && l == m_wr);
      m_occ[l]    = m_occ[l] + int'(push_fire && l == m_wr) - int'(pop_fire && l == m_rd);
      m_ret[l]    = int'(pop_fire && l == m_rd);
    end
    if (push_fire) begin
      m_queue.push_back(ref_pattern[m_push_cnt % 16]);
      m_push_cnt++;
      row_push_cnt++;
      m_wr = (m_wr + 1) % n_lanes;
    end
    if (pop_fire) begin
      m_rd = (m_rd + 1) % n_lanes;
    end
    m_valid = pop_fire;
  endtask

  initial begin
    int total;
    int err_start;
    void'($urandom(85826));
    set_row(0, "idle", mode_low, mode_low, 2, 0, 0);
    set_row(1, "fill", mode_high, mode_low, 21, 16, 0);
    set_row(2, "drain", mode_low, mode_high, 20, 0, 16);
    set_row(3, "refill", mode_high, mode_low, 20, 16, 0);
    set_row(4, "credit_pop", mode_low, mode_high, 1, 0, 0);
    set_row(5, "credit_wait", mode_low, mode_low, 3, 0, 1);
    set_row(6, "credit_push", mode_high, mode_low, 4, 1, 0);
    set_row(7, "mixed", mode_rand, mode_rand, 200, -1, -1);
    set_row(8, "final_drain", mode_low, mode_high, 40, 0, -1);
    total = 0;
    for (int r = 0; r < n_rows; r++) begin
      total += row_cycles[r];
    end
    cycle_limit = total + 16 + 50;
    // model matches the reset state
    for (int l = 0; l < n_lanes; l++) begin
      m_credit[l] = depth;
      m_occ[l]    = 0;
      m_ret[l]    = 0;
    end
    m_wr       = 0;
    m_rd       = 0;
    m_push_cnt = 0;
    m_valid    = 1'b0;
    repeat (16) @(posedge clk);
    arst_n <= 1'b1;
    @(negedge clk);
    checks++;
    if (push_ready !== 1'b1 || out_valid !== 1'b0) begin
      errors++;
      $display("CHECK FAILED t=%0t push_ready/out_valid expected 1/0 got %0b/%0b", $time,
               push_ready, out_valid);
    end
    // ------------------------------
    // table loop
    // ------------------------------
    for (int r = 0; r < n_rows; r++) begin
      err_start    = errors;
      row_push_cnt = 0;
      row_out_cnt  = 0;
      for (int c = 0; c < row_cycles[r]; c++) begin
        @(posedge clk);
        push_en <= pick(row_push[r]);
        pop_en  <= pick(row_pop[r]);
        @(negedge clk);
        step_model();
      end
      if (row_exp_push[r] >= 0 && row_push_cnt != row_exp_push[r]) begin
        errors++;
        $display("CHECK FAILED t=%0t accepted pushes expected %0d got %0d", $time,
                 row_exp_push[r], row_push_cnt);
      end
      if (row_exp_out[r] >= 0 && row_out_cnt != row_exp_out[r]) begin
        errors++;
        $display("CHECK FAILED t=%0t out_valid words expected %0d got %0d", $time,
                 row_exp_out[r], row_out_cnt);
      end
      $display("test %s: pushes %0d, outputs %0d, errors %0d", row_name[r], row_push_cnt,
               row_out_cnt, errors - err_start);
    end
    if (m_queue.size() != 0) begin
      errors++;
      $display("model still holds %0d words after the final drain", m_queue.size());
    end
    $display("tests %0d, checks %0d, pushes %0d, errors %0d", n_rows, checks, m_push_cnt,
             errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

//--- flist.f
fifo_demo_pkg.sv
lane_if.sv
pattern_source.sv
flip_flop_fifo_with_counter.sv
lane_drain.sv
fifo_demo_top.sv
tb_fifo_demo.sv

//--- run.sh
#!/bin/sh
# build the FIFO demo testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_fifo_demo -f flist.f -o tb_fifo_demo
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

out=$(./obj_dir/tb_fifo_demo)
status=$?
printf '%s\n' "$out"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

# the testbench prints its verdict on a line of its own
if printf '%s\n' "$out" | grep -qx "PASS: all tests"; then
  exit 0
else
  echo "simulation did not pass"
  exit 1
fi
